// ==== source/axi4l_reg_pkg.sv ====
`default_nettype none

package axi4l_reg_pkg;

    // ==============================
    // Bus widths
    // ==============================

    localparam int addr_width = 12;
    localparam int data_width = 32;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [data_width-1:0] data_t;
    typedef logic [1:0]            resp_t;

    // ==============================
    // Channel bundles
    // ==============================

    // Everything the master drives, all five channels together
    typedef struct packed {
        logic  awvalid;
        addr_t awaddr;
        logic  wvalid;
        data_t wdata;
        logic  bready;
        logic  arvalid;
        addr_t araddr;
        logic  rready;
    } axi4l_req_t;

    // Everything the slave drives back
    typedef struct packed {
        logic  awready;
        logic  wready;
        logic  bvalid;
        resp_t bresp;
        logic  arready;
        logic  rvalid;
        data_t rdata;
        resp_t rresp;
    } axi4l_rsp_t;

    // ==============================
    // Control record
    // ==============================

    // Sits in the low 16 bits of a bus word, enable at bit 15
    typedef struct packed {
        logic        enable;
        logic [2:0]  mode;
        logic [11:0] divisor;
    } ctrl_reg_t;

endpackage

`default_nettype wire

// ==== source/axi4l_register.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi4l_register #(
    parameter int              num   = 4,
    parameter type             reg_t = axi4l_reg_pkg::data_t,
    parameter reg_t [num-1:0]  init  = '0
) (
    input  wire logic                       s_axi4l,
    input  wire logic                       rst_n,
    input  wire axi4l_reg_pkg::axi4l_req_t  req,
    output      axi4l_reg_pkg::axi4l_rsp_t  rsp,
    output      reg_t [num-1:0]             value
);

    localparam int idx_width = (num > 1) ? $clog2(num) : 1;
    localparam int byte_bits = $clog2(axi4l_reg_pkg::data_width / 8);
    localparam int reg_bits  = $bits(reg_t);

    // Payload placed in the low bits of a bus word, upper bits zero
    function automatic axi4l_reg_pkg::data_t zero_ext(input reg_t r);
        axi4l_reg_pkg::data_t d;
        d = '0;
        d[reg_bits-1:0] = r;
        return d;
    endfunction

    // ==============================
    // Address decode
    // ==============================

    logic [idx_width-1:0] widx;
    logic [idx_width-1:0] ridx;

    // Bits above the index are ignored, so registers alias there
    assign widx = req.awaddr[byte_bits +: idx_width];
    assign ridx = req.araddr[byte_bits +: idx_width];

    // ==============================
    // Register storage
    // ==============================

    reg_t [num-1:0] regs;
    logic           bvalid;
    logic           wr_ready;
    logic           wr_fire;

    // Room for a new write when no response is waiting or it leaves now
    assign wr_ready = !bvalid || req.bready;

    // Address and data are only taken together
    assign wr_fire = req.awvalid && req.wvalid && wr_ready;

    always_ff @(posedge s_axi4l or negedge rst_n) begin
        if (!rst_n) begin
            regs   <= init;
            bvalid <= 1'b0;
        end else begin
            if (req.bready) begin
                bvalid <= 1'b0;
            end
            if (wr_fire) begin
                regs[widx] <= req.wdata[reg_bits-1:0];
                bvalid     <= 1'b1;
            end
        end
    end

    assign value = regs;

    assign rsp.awready = wr_ready && req.wvalid;
    assign rsp.wready  = wr_ready && req.awvalid;
    assign rsp.bvalid  = bvalid;
    assign rsp.bresp   = 2'b00;

    // ==============================
    // Read channel
    // ==============================

    axi4l_reg_pkg::data_t rdata;
    logic                 rvalid;
    logic                 rd_ready;
    logic                 rd_fire;

    assign rd_ready = !rvalid || req.rready;
    assign rd_fire  = req.arvalid && rd_ready;

    always_ff @(posedge s_axi4l or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else begin
            if (req.rready) begin
                rvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end
        end
    end

    // Read data is held until the next accepted read replaces it
    always_ff @(posedge s_axi4l) begin
        if (rd_fire) begin
            rdata <= zero_ext(regs[ridx]);
        end
    end

    assign rsp.arready = rd_ready;
    assign rsp.rvalid  = rvalid;
    assign rsp.rdata   = rdata;
    assign rsp.rresp   = 2'b00;

endmodule

`default_nettype wire

// ==== source/axi4l_bank_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi4l_bank_mux #(
    parameter int bank_bit = 4
) (
    input  wire logic                       s_axi4l,
    input  wire logic                       rst_n,
    input  wire axi4l_reg_pkg::axi4l_req_t  req,
    output      axi4l_reg_pkg::axi4l_rsp_t  rsp,
    output      axi4l_reg_pkg::axi4l_req_t  word_req,
    input  wire axi4l_reg_pkg::axi4l_rsp_t  word_rsp,
    output      axi4l_reg_pkg::axi4l_req_t  ctrl_req,
    input  wire axi4l_reg_pkg::axi4l_rsp_t  ctrl_rsp
);

    // Copy of the master request with valids and readies masked for one bank
    function automatic axi4l_reg_pkg::axi4l_req_t route(
        input axi4l_reg_pkg::axi4l_req_t src,
        input logic                      w_hit,
        input logic                      r_hit,
        input logic                      b_own,
        input logic                      r_own
    );
        axi4l_reg_pkg::axi4l_req_t dst;
        dst         = src;
        dst.awvalid = src.awvalid && w_hit;
        dst.wvalid  = src.wvalid && w_hit;
        dst.bready  = src.bready && b_own;
        dst.arvalid = src.arvalid && r_hit;
        dst.rready  = src.rready && r_own;
        return dst;
    endfunction

    // ==============================
    // Bank decode
    // ==============================

    // High selects the control bank
    logic wr_sel;
    logic rd_sel;

    assign wr_sel = req.awaddr[bank_bit];
    assign rd_sel = req.araddr[bank_bit];

    // Bank that owns the response currently in flight on each channel
    logic b_bank;
    logic r_bank;

    logic b_pending;
    logic r_pending;

    assign b_pending = b_bank ? ctrl_rsp.bvalid : word_rsp.bvalid;
    assign r_pending = r_bank ? ctrl_rsp.rvalid : word_rsp.rvalid;

    // A channel is open when nothing waits or the waiting response leaves now.
    // This keeps a fast bank from overtaking a response still held by the other.
    logic wr_open;
    logic rd_open;

    assign wr_open = !b_pending || req.bready;
    assign rd_open = !r_pending || req.rready;

    // ==============================
    // Request routing
    // ==============================

    always_comb begin
        word_req = route(req, wr_open && !wr_sel, rd_open && !rd_sel, !b_bank, !r_bank);
        ctrl_req = route(req, wr_open && wr_sel, rd_open && rd_sel, b_bank, r_bank);
    end

    // ==============================
    // Response selection
    // ==============================

    logic wr_fire;
    logic rd_fire;

    assign wr_fire = req.awvalid && rsp.awready;
    assign rd_fire = req.arvalid && rsp.arready;

    always_ff @(posedge s_axi4l or negedge rst_n) begin
        if (!rst_n) begin
            b_bank <= 1'b0;
            r_bank <= 1'b0;
        end else begin
            if (wr_fire) begin
                b_bank <= wr_sel;
            end
            if (rd_fire) begin
                r_bank <= rd_sel;
            end
        end
    end

    // ==============================
    // Response merge
    // ==============================

    always_comb begin
        // Ready comes from the bank the address points at
        if (wr_sel) begin
            rsp.awready = ctrl_rsp.awready && wr_open;
            rsp.wready  = ctrl_rsp.wready && wr_open;
        end else begin
            rsp.awready = word_rsp.awready && wr_open;
            rsp.wready  = word_rsp.wready && wr_open;
        end

        if (rd_sel) begin
            rsp.arready = ctrl_rsp.arready && rd_open;
        end else begin
            rsp.arready = word_rsp.arready && rd_open;
        end

        // Responses come from the bank that took the request
        if (b_bank) begin
            rsp.bvalid = ctrl_rsp.bvalid;
            rsp.bresp  = ctrl_rsp.bresp;
        end else begin
            rsp.bvalid = word_rsp.bvalid;
            rsp.bresp  = word_rsp.bresp;
        end

        if (r_bank) begin
            rsp.rvalid = ctrl_rsp.rvalid;
            rsp.rdata  = ctrl_rsp.rdata;
            rsp.rresp  = ctrl_rsp.rresp;
        end else begin
            rsp.rvalid = word_rsp.rvalid;
            rsp.rdata  = word_rsp.rdata;
            rsp.rresp  = word_rsp.rresp;
        end
    end

endmodule

`default_nettype wire

// ==== source/axi4l_reg_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi4l_reg_subsystem #(
    parameter int num_words = 4,
    parameter int num_ctrl  = 2,
    parameter int bank_bit  = 4,

    // Word bank reset contents, index 0 in the low word
    parameter axi4l_reg_pkg::data_t [num_words-1:0] word_init = {
        32'hcafe_0003,
        32'hcafe_0002,
        32'hcafe_0001,
        32'hcafe_0000
    },

    // Index 0 is enable=1 mode=2 divisor=0x064, index 1 is enable=0 mode=5 divisor=0x3e8
    parameter axi4l_reg_pkg::ctrl_reg_t [num_ctrl-1:0] ctrl_init = {
        16'h53e8,
        16'ha064
    }
) (
    input  wire logic                                 s_axi4l,
    input  wire logic                                 rst_n,
    input  wire axi4l_reg_pkg::axi4l_req_t            req,
    output      axi4l_reg_pkg::axi4l_rsp_t            rsp,
    output      axi4l_reg_pkg::data_t [num_words-1:0] word_value,
    output      axi4l_reg_pkg::ctrl_reg_t [num_ctrl-1:0] ctrl_value
);

    axi4l_reg_pkg::axi4l_req_t word_req;
    axi4l_reg_pkg::axi4l_rsp_t word_rsp;
    axi4l_reg_pkg::axi4l_req_t ctrl_req;
    axi4l_reg_pkg::axi4l_rsp_t ctrl_rsp;

    // ==============================
    // Bank select
    // ==============================

    axi4l_bank_mux #(
        .bank_bit (bank_bit)
    ) axi4l_bank_mux_inst (
        .s_axi4l  (s_axi4l),
        .rst_n    (rst_n),
        .req      (req),
        .rsp      (rsp),
        .word_req (word_req),
        .word_rsp (word_rsp),
        .ctrl_req (ctrl_req),
        .ctrl_rsp (ctrl_rsp)
    );

    // ==============================
    // Register banks
    // ==============================

    axi4l_register #(
        .num   (num_words),
        .reg_t (axi4l_reg_pkg::data_t),
        .init  (word_init)
    ) word_bank_inst (
        .s_axi4l (s_axi4l),
        .rst_n   (rst_n),
        .req     (word_req),
        .rsp     (word_rsp),
        .value   (word_value)
    );

    axi4l_register #(
        .num   (num_ctrl),
        .reg_t (axi4l_reg_pkg::ctrl_reg_t),
        .init  (ctrl_init)
    ) ctrl_bank_inst (
        .s_axi4l (s_axi4l),
        .rst_n   (rst_n),
        .req     (ctrl_req),
        .rsp     (ctrl_rsp),
        .value   (ctrl_value)
    );

endmodule

`default_nettype wire

// ==== dv/axi4l_reg_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi4l_reg_props (
    input wire logic                      s_axi4l,
    input wire logic                      rst_n,
    input wire axi4l_reg_pkg::axi4l_req_t req,
    input wire axi4l_reg_pkg::axi4l_rsp_t rsp
);

    // No response may appear during reset or in the cycle right after it
    idle_after_reset: assert property (
        @(posedge s_axi4l) !rst_n |=> !rsp.bvalid && !rsp.rvalid
    ) else $error("response valid high after reset");

    b_held: assert property (
        @(posedge s_axi4l) disable iff (!rst_n)
        rsp.bvalid && !req.bready |=> rsp.bvalid
    ) else $error("bvalid dropped while bready was low");

    r_held: assert property (
        @(posedge s_axi4l) disable iff (!rst_n)
        rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata)
    ) else $error("rvalid or rdata changed while rready was low");

    b_follows_aw: assert property (
        @(posedge s_axi4l) disable iff (!rst_n)
        req.awvalid && rsp.awready |=> rsp.bvalid
    ) else $error("bvalid did not follow the write transfer");

endmodule

bind axi4l_reg_subsystem axi4l_reg_props axi4l_reg_props_inst (
    .s_axi4l (s_axi4l),
    .rst_n   (rst_n),
    .req     (req),
    .rsp     (rsp)
);

`default_nettype wire

// ==== dv/tb_axi4l_reg_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi4l_reg_subsystem;

    localparam int bank_bit   = 4;
    localparam int wait_limit = 40;

    typedef struct {
        string       name;
        bit          write;
        logic [11:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp;
    } step_t;

    logic                           s_axi4l;
    logic                           rst_n;
    axi4l_reg_pkg::axi4l_req_t      req;
    axi4l_reg_pkg::axi4l_rsp_t      rsp;
    axi4l_reg_pkg::data_t     [3:0] word_value;
    axi4l_reg_pkg::ctrl_reg_t [1:0] ctrl_value;

    logic [31:0] word_model [4];
    logic [15:0] ctrl_model [2];
    step_t       steps [$];
    integer      seed;
    int          errors;
    int          checks;

    axi4l_reg_subsystem axi4l_reg_subsystem_inst (
        .s_axi4l    (s_axi4l),
        .rst_n      (rst_n),
        .req        (req),
        .rsp        (rsp),
        .word_value (word_value),
        .ctrl_value (ctrl_value)
    );

    initial begin
        s_axi4l = 1'b0;
        forever #50 s_axi4l = ~s_axi4l;
    end

    // ==============================
    // Reference model
    // ==============================

    function automatic void load_init_model();
        word_model = '{32'hcafe_0000, 32'hcafe_0001, 32'hcafe_0002, 32'hcafe_0003};
        ctrl_model = '{16'ha064, 16'h53e8};
    endfunction

    // Word index is addr[3:2], the control bank decodes addr[2] only
    function automatic void model_write(logic [11:0] addr, logic [31:0] data);
        if (addr[bank_bit]) ctrl_model[addr[2]] = data[15:0];
        else word_model[addr[3:2]] = data;
    endfunction

    function automatic logic [31:0] expected_read(logic [11:0] addr);
        return addr[bank_bit] ? {16'h0000, ctrl_model[addr[2]]} : word_model[addr[3:2]];
    endfunction

    // Even steps hit the word bank, odd steps the control bank
    function automatic logic [11:0] stream_addr(int k);
        return (k % 2 == 1) ? 12'(16 + 4 * ((k / 2) % 2)) : 12'(4 * ((k / 2) % 4));
    endfunction

    function automatic void add_step(string name, bit write, logic [11:0] addr);
        logic [31:0] data;
        data = write ? $random(seed) : 32'h0;
        steps.push_back(step_t'{name, write, addr, data, expected_read(addr)});
        if (write) model_write(addr, data);
    endfunction

    function automatic void build_table();
        for (int i = 0; i < 6; i++) begin
            add_step($sformatf("reset read %0d", i), 1'b0, 12'(4 * i));
        end
        for (int i = 0; i < 4; i++) begin
            add_step($sformatf("word write %0d", i), 1'b1, 12'(4 * i));
            add_step($sformatf("word readback %0d", i), 1'b0, 12'(4 * i));
        end
        for (int i = 0; i < 2; i++) begin
            add_step($sformatf("ctrl write %0d", i), 1'b1, 12'(16 + 4 * i));
            add_step($sformatf("ctrl readback %0d", i), 1'b0, 12'(16 + 4 * i));
        end
        // Bit 3 and the bits above the bank bit are not decoded
        add_step("ctrl alias bit 3 write", 1'b1, 12'h018);
        add_step("ctrl alias bit 3 readback", 1'b0, 12'h010);
        add_step("ctrl alias high write", 1'b1, 12'h234);
        add_step("ctrl alias high readback", 1'b0, 12'h014);
        add_step("word alias high write", 1'b1, 12'h048);
        add_step("word alias high readback", 1'b0, 12'h008);
    endfunction

    // ==============================
    // Checks
    // ==============================

    task automatic compare(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic flag_problem(string what);
        errors++;
        $display("Error: %s", what);
    endtask

    task automatic compare_ports(string name);
        for (int i = 0; i < 4; i++) begin
            compare($sformatf("%s word_value[%0d]", name, i), word_model[i], word_value[i]);
        end
        for (int i = 0; i < 2; i++) begin
            compare($sformatf("%s ctrl_value[%0d]", name, i), {16'h0000, ctrl_model[i]},
                {16'h0000, ctrl_value[i].enable, ctrl_value[i].mode, ctrl_value[i].divisor});
        end
    endtask

    // ==============================
    // Bus traffic
    // ==============================

    task automatic apply_step(step_t s, int stall);
        int          cycles;
        logic [31:0] first;
        @(posedge s_axi4l);
        req.awvalid <= s.write;
        req.wvalid  <= s.write;
        req.arvalid <= !s.write;
        req.awaddr  <= s.addr;
        req.araddr  <= s.addr;
        req.wdata   <= s.wdata;
        cycles = 0;
        @(negedge s_axi4l);
        while (!(s.write ? rsp.awready && rsp.wready : rsp.arready) && cycles < wait_limit) begin
            @(negedge s_axi4l);
            cycles++;
        end
        if (cycles == wait_limit) flag_problem({s.name, ": the request was never accepted"});
        @(posedge s_axi4l);
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
        req.arvalid <= 1'b0;
        req.bready  <= (stall == 0);
        req.rready  <= (stall == 0);
        @(negedge s_axi4l);
        if (!(s.write ? rsp.bvalid : rsp.rvalid)) begin
            flag_problem({s.name, ": no response one cycle after the request"});
        end
        first = rsp.rdata;
        repeat (stall) begin
            @(negedge s_axi4l);
            if (!(s.write ? rsp.bvalid : rsp.rvalid) || rsp.rdata !== first) begin
                flag_problem({s.name, ": the response changed while it was stalled"});
            end
        end
        if (stall > 0) begin
            @(posedge s_axi4l);
            req.bready <= 1'b1;
            req.rready <= 1'b1;
            @(negedge s_axi4l);
        end
        compare({s.name, " resp"}, 32'h0, {30'h0, s.write ? rsp.bresp : rsp.rresp});
        if (s.write) model_write(s.addr, s.wdata);
        else compare(s.name, s.exp, rsp.rdata);
        @(posedge s_axi4l);
        @(negedge s_axi4l);
        if (s.write ? rsp.bvalid : rsp.rvalid) begin
            flag_problem({s.name, ": the response was delivered twice"});
        end
        if (s.write) compare_ports(s.name);
    endtask

    // Both channels busy every cycle, each alternating between the banks
    task automatic stream_test(int n);
        logic [11:0] waddr;
        logic [11:0] raddr;
        logic [31:0] data;
        logic [31:0] exp_q [$];
        for (int k = 0; k <= n; k++) begin
            waddr = stream_addr(k);
            raddr = stream_addr(k + 1);
            data  = $random(seed);
            @(posedge s_axi4l);
            req.awvalid <= (k < n);
            req.wvalid  <= (k < n);
            req.arvalid <= (k < n);
            req.awaddr  <= waddr;
            req.araddr  <= raddr;
            req.wdata   <= data;
            @(negedge s_axi4l);
            if (k < n && !(rsp.awready && rsp.wready && rsp.arready)) begin
                flag_problem($sformatf("stream request %0d was not accepted at once", k));
            end
            if (k > 0 && !(rsp.bvalid && rsp.rvalid)) begin
                flag_problem($sformatf("stream response %0d was not one cycle late", k - 1));
            end
            if (k > 0) compare($sformatf("stream read %0d", k - 1), exp_q[k - 1], rsp.rdata);
            exp_q.push_back(expected_read(raddr));
            if (k < n) model_write(waddr, data);
        end
    endtask

    initial begin
        int stall;
        seed   = 32123;
        errors = 0;
        checks = 0;
        rst_n  = 1'b0;
        req    = '0;
        load_init_model();
        build_table();
        load_init_model();
        repeat (4) @(posedge s_axi4l);
        rst_n      <= 1'b1;
        req.bready <= 1'b1;
        req.rready <= 1'b1;
        @(negedge s_axi4l);
        compare_ports("reset contents");
        foreach (steps[i]) begin
            stall = {$random(seed)} % 4;
            apply_step(steps[i], stall);
        end
        stream_test(8);
        compare_ports("final contents");
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
source/axi4l_reg_pkg.sv
source/axi4l_register.sv
source/axi4l_bank_mux.sv
source/axi4l_reg_subsystem.sv
dv/axi4l_reg_props.sv
dv/tb_axi4l_reg_subsystem.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_axi4l_reg_subsystem \
    -f src.f

output=$(./obj_dir/Vtb_axi4l_reg_subsystem)
echo "$output"

if echo "$output" | grep -q "^ALL TESTS PASSED$"; then
    exit 0
fi
exit 1
